// ==== hw/cmd_fifo.sv ====
`timescale 1ns/10ps

module cmd_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  loader_pkg::load_cmd_t in_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output loader_pkg::load_cmd_t out_data
);

  localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_width = $clog2(fifo_depth + 1);

  loader_pkg::load_cmd_t slots [fifo_depth];
  logic [ptr_width-1:0]  wr_ptr_q;
  logic [ptr_width-1:0]  rd_ptr_q;
  logic [cnt_width-1:0]  count_q;
  logic                  push;
  logic                  pop;

  // circular pointer step, wraps for any depth
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready  = count_q != cnt_width'(fifo_depth);
  assign out_valid = count_q != '0;
  assign out_data  = slots[rd_ptr_q];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clock) begin
    if (push) begin
      slots[wr_ptr_q] <= in_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // push and pop together leave the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== hw/dest_ram.sv ====
`timescale 1ns/10ps

module dest_ram #(
  parameter int addr_width = 10
) (
  input  logic                              clock,
  mem_wr_if.slave                           wr,
  input  logic [addr_width-1:0]             raddr,
  output logic [loader_pkg::word_width-1:0] rdata
);

  logic [loader_pkg::word_width-1:0] words [2**addr_width];

  // out of range addresses are dropped, not aliased
  always_ff @(posedge clock) begin
    if (wr.we && wr.full_addr_ok) begin
      words[wr.addr] <= wr.wdata;
    end
  end

  // host readback port
  always_ff @(posedge clock) begin
    rdata <= words[raddr];
  end

endmodule

// ==== hw/loader_pkg.sv ====
package loader_pkg;

  // data path and command widths
  localparam int word_width = 32;
  localparam int cmd_width  = 37;

  // destination select values
  localparam logic sel_im = 1'b0;
  localparam logic sel_dm = 1'b1;

  // load command as sent by the host, MSB first
  typedef struct packed {
    logic        spare;
    logic        ir_rst;
    logic        ir_en;
    logic        ir_select;
    // reserved, never decoded
    logic        ir_read;
    logic [15:0] start_address;
    // size in bits, word count is size / 32
    logic [15:0] size;
  } load_cmd_t;

  // controller states
  typedef enum logic [1:0] {
    idle  = 2'd0,
    copy  = 2'd1,
    drain = 2'd2
  } ctrl_state_t;

endpackage

// ==== hw/main_mem.sv ====
`timescale 1ns/10ps

module main_mem #(
  parameter int main_addr_width = 12
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              we,
  input  logic [main_addr_width-1:0]        waddr,
  input  logic [loader_pkg::word_width-1:0] wdata,
  input  logic                              rd_en,
  input  logic [main_addr_width-1:0]        rd_addr,
  output logic [loader_pkg::word_width-1:0] rd_data
);

  logic [loader_pkg::word_width-1:0] words [2**main_addr_width];

  // host preload port
  always_ff @(posedge clock) begin
    if (we) begin
      words[waddr] <= wdata;
    end
  end

  // controller read, data one cycle after rd_en
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= words[rd_addr];
    end
  end

endmodule

// ==== hw/mem_controller.sv ====
`timescale 1ns/10ps

module mem_controller #(
  parameter int im_start        = 'h7F,
  parameter int main_addr_width = 12
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              q_valid,
  output logic                              q_ready,
  input  loader_pkg::load_cmd_t             q_cmd,
  output logic                              rd_en,
  output logic [main_addr_width-1:0]        rd_addr,
  input  logic [loader_pkg::word_width-1:0] rd_data,
  mem_wr_if.master                          im_wr,
  mem_wr_if.master                          dm_wr,
  output logic                              busy,
  output logic                              load_im_done,
  output logic                              ir_enable,
  output logic                              eop,
  output logic [15:0]                       total_ir
);

  localparam int im_aw = im_wr.addr_width;
  localparam int dm_aw = dm_wr.addr_width;

  loader_pkg::ctrl_state_t    state_q;
  logic                       pop;
  logic [10:0]                n_words;
  logic [10:0]                words_left_q;
  logic [15:0]                rd_idx_q;
  logic                       sel_q;
  logic [main_addr_width-1:0] src_base_q;
  logic [15:0]                dst_base_q;
  // write stage, one cycle behind the read
  logic                       wr_im_q;
  logic                       wr_dm_q;
  logic [15:0]                wr_addr_q;

  assign q_ready = (state_q == loader_pkg::idle) && !eop;
  assign pop     = q_valid && q_ready;
  assign n_words = q_cmd.size[15:5];
  assign busy    = state_q != loader_pkg::idle;

  assign rd_en   = state_q == loader_pkg::copy;
  assign rd_addr = src_base_q + rd_idx_q[main_addr_width-1:0];

  // read data goes straight to whichever RAM is targeted
  assign im_wr.we           = wr_im_q;
  assign im_wr.addr         = wr_addr_q[im_aw-1:0];
  assign im_wr.wdata        = rd_data;
  assign im_wr.full_addr_ok = (wr_addr_q >> im_aw) == '0;

  assign dm_wr.we           = wr_dm_q;
  assign dm_wr.addr         = wr_addr_q[dm_aw-1:0];
  assign dm_wr.wdata        = rd_data;
  assign dm_wr.full_addr_ok = (wr_addr_q >> dm_aw) == '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= loader_pkg::idle;
      words_left_q <= '0;
      rd_idx_q     <= '0;
      sel_q        <= loader_pkg::sel_im;
      wr_im_q      <= 1'b0;
      wr_dm_q      <= 1'b0;
      load_im_done <= 1'b0;
      ir_enable    <= 1'b0;
      eop          <= 1'b0;
      total_ir     <= '0;
    end else begin
      wr_im_q <= rd_en && (sel_q == loader_pkg::sel_im);
      wr_dm_q <= rd_en && (sel_q == loader_pkg::sel_dm);
      case (state_q)
        loader_pkg::idle: begin
          if (pop) begin
            ir_enable    <= q_cmd.ir_en;
            total_ir     <= {5'b0, n_words};
            rd_idx_q     <= '0;
            words_left_q <= n_words;
            sel_q        <= q_cmd.ir_select;
            if (q_cmd.ir_rst) begin
              load_im_done <= 1'b0;
            end
            // all-zero word ends the program, sticky until reset
            if (q_cmd == '0) begin
              eop <= 1'b1;
            end else if (n_words != '0) begin
              state_q <= loader_pkg::copy;
            end
          end
        end
        loader_pkg::copy: begin
          rd_idx_q     <= rd_idx_q + 16'd1;
          words_left_q <= words_left_q - 11'd1;
          if (words_left_q == 11'd1) begin
            state_q <= loader_pkg::drain;
          end
        end
        loader_pkg::drain: begin
          // last write lands at this edge
          state_q <= loader_pkg::idle;
          if (sel_q == loader_pkg::sel_im) begin
            load_im_done <= 1'b1;
          end
        end
        default: state_q <= loader_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      src_base_q <= q_cmd.start_address[main_addr_width-1:0];
      dst_base_q <= (q_cmd.ir_select == loader_pkg::sel_dm) ? 16'd0 : 16'(im_start);
    end
    wr_addr_q <= dst_base_q + rd_idx_q;
  end

endmodule

// ==== hw/mem_loader_top.sv ====
`timescale 1ns/10ps

module mem_loader_top #(
  parameter int im_start        = 'h7F,
  parameter int im_addr_width   = 10,
  parameter int dm_addr_width   = 10,
  parameter int main_addr_width = 12,
  parameter int fifo_depth      = 4
) (
  input  logic                              clock,
  input  logic                              reset,
  // host preload of main memory
  input  logic                              main_we,
  input  logic [main_addr_width-1:0]        main_waddr,
  input  logic [loader_pkg::word_width-1:0] main_wdata,
  // load commands
  input  logic                              cmd_valid,
  output logic                              cmd_ready,
  input  logic [loader_pkg::cmd_width-1:0]  cmd_data,
  // readback
  input  logic [im_addr_width-1:0]          im_raddr,
  output logic [loader_pkg::word_width-1:0] im_rdata,
  input  logic [dm_addr_width-1:0]          dm_raddr,
  output logic [loader_pkg::word_width-1:0] dm_rdata,
  // status
  output logic                              load_im_done,
  output logic                              ir_enable,
  output logic                              eop,
  output logic                              busy,
  output logic [15:0]                       total_ir
);

  loader_pkg::load_cmd_t             host_cmd;
  loader_pkg::load_cmd_t             q_cmd;
  logic                              q_valid;
  logic                              q_ready;
  logic                              rd_en;
  logic [main_addr_width-1:0]        rd_addr;
  logic [loader_pkg::word_width-1:0] rd_data;

  mem_wr_if #(.addr_width(im_addr_width)) im_wr ();
  mem_wr_if #(.addr_width(dm_addr_width)) dm_wr ();

  assign host_cmd = cmd_data;

  cmd_fifo #(
    .fifo_depth(fifo_depth)
  ) u_cmd_fifo (
    .clock    (clock),
    .reset    (reset),
    .in_valid (cmd_valid),
    .in_ready (cmd_ready),
    .in_data  (host_cmd),
    .out_valid(q_valid),
    .out_ready(q_ready),
    .out_data (q_cmd)
  );

  mem_controller #(
    .im_start       (im_start),
    .main_addr_width(main_addr_width)
  ) u_mem_controller (
    .clock       (clock),
    .reset       (reset),
    .q_valid     (q_valid),
    .q_ready     (q_ready),
    .q_cmd       (q_cmd),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .im_wr       (im_wr.master),
    .dm_wr       (dm_wr.master),
    .busy        (busy),
    .load_im_done(load_im_done),
    .ir_enable   (ir_enable),
    .eop         (eop),
    .total_ir    (total_ir)
  );

  main_mem #(
    .main_addr_width(main_addr_width)
  ) u_main_mem (
    .clock  (clock),
    .reset  (reset),
    .we     (main_we),
    .waddr  (main_waddr),
    .wdata  (main_wdata),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  dest_ram #(
    .addr_width(im_addr_width)
  ) u_im_ram (
    .clock(clock),
    .wr   (im_wr.slave),
    .raddr(im_raddr),
    .rdata(im_rdata)
  );

  dest_ram #(
    .addr_width(dm_addr_width)
  ) u_dm_ram (
    .clock(clock),
    .wr   (dm_wr.slave),
    .raddr(dm_raddr),
    .rdata(dm_rdata)
  );

endmodule

// ==== hw/mem_wr_if.sv ====
`timescale 1ns/10ps

interface mem_wr_if #(
  parameter int addr_width = 10
);

  logic                              we;
  logic [addr_width-1:0]             addr;
  logic [loader_pkg::word_width-1:0] wdata;
  // high when the full destination address fits in the RAM
  logic                              full_addr_ok;

  modport master (
    output we, addr, wdata, full_addr_ok
  );

  modport slave (
    input we, addr, wdata, full_addr_ok
  );

endinterface

// ==== mem_loader.f ====
hw/loader_pkg.sv
hw/mem_wr_if.sv
hw/cmd_fifo.sv
hw/mem_controller.sv
hw/main_mem.sv
hw/dest_ram.sv
hw/mem_loader_top.sv
tb/tb_mem_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mem_loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f mem_loader.f --top-module tb_mem_loader \
  -Mdir obj_dir -o tb_mem_loader
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mem_loader > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -qx "NO ERRORS" "$log"
if [ $? -ne 0 ]; then
  echo "simulation did not report a pass"
  exit 1
fi

echo "simulation passed"
exit 0

// ==== tb/tb_mem_loader.sv ====
`timescale 1ns/10ps

module tb_mem_loader;

  localparam int clk_period    = 8;
  localparam int im_start      = 'h7F;
  localparam int main_words    = 4096;
  localparam int preload_words = 256;
  // preload plus all tests with a wide margin
  localparam int budget_cycles = 2 * (preload_words + 1000);
  localparam int wait_limit    = 200;

  logic        clock;
  logic        reset;
  logic        main_we;
  logic [11:0] main_waddr;
  logic [31:0] main_wdata;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [36:0] cmd_data;
  logic [9:0]  im_raddr;
  logic [31:0] im_rdata;
  logic [9:0]  dm_raddr;
  logic [31:0] dm_rdata;
  logic        load_im_done;
  logic        ir_enable;
  logic        eop;
  logic        busy;
  logic [15:0] total_ir;

  // reference copies of the memories and status flags
  logic [31:0] main_model [main_words];
  logic [31:0] im_model [1024];
  logic [31:0] dm_model [1024];
  logic        exp_done;
  logic        exp_ir_en;
  logic [15:0] exp_total;
  logic        saw_full;
  logic [31:0] rng_state;

  mem_loader_top #(
    .im_start       (im_start),
    .im_addr_width  (10),
    .dm_addr_width  (10),
    .main_addr_width(12),
    .fifo_depth     (4)
  ) u_mem_loader_top (
    .clock       (clock),
    .reset       (reset),
    .main_we     (main_we),
    .main_waddr  (main_waddr),
    .main_wdata  (main_wdata),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_data    (cmd_data),
    .im_raddr    (im_raddr),
    .im_rdata    (im_rdata),
    .dm_raddr    (dm_raddr),
    .dm_rdata    (dm_rdata),
    .load_im_done(load_im_done),
    .ir_enable   (ir_enable),
    .eop         (eop),
    .busy        (busy),
    .total_ir    (total_ir)
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic loader_pkg::load_cmd_t make_cmd(input logic rst, input logic en,
                                                     input logic sel, input logic [15:0] start,
                                                     input logic [15:0] size);
    loader_pkg::load_cmd_t c;
    c = '0;
    c.ir_rst        = rst;
    c.ir_en         = en;
    c.ir_select     = sel;
    c.start_address = start;
    c.size          = size;
    return c;
  endfunction

  // one clock with inputs changing 1 ns after the edge
  task automatic tick();
    @(posedge clock);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t ns: %s, got %h, expected %h",
                          $time, what, actual, expected));
    end
  endtask

  task automatic send_cmd(input loader_pkg::load_cmd_t c);
    int waited;
    waited = 0;
    cmd_valid = 1'b1;
    cmd_data  = c;
    while (!cmd_ready) begin
      saw_full = 1'b1;
      tick();
      waited++;
      if (waited > wait_limit) begin
        abort_run("a command was never accepted, cmd_ready stayed low");
      end
    end
    // transfer happens at this edge
    tick();
    cmd_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (u_mem_loader_top.q_valid || busy) begin
      tick();
      waited++;
      if (waited > wait_limit) begin
        abort_run("the controller did not return to idle");
      end
    end
  endtask

  // expected effect of one popped command
  task automatic apply_model(input loader_pkg::load_cmd_t c);
    int n;
    int src;
    n = int'(c.size >> 5);
    exp_ir_en = c.ir_en;
    exp_total = 16'(n);
    if (c.ir_rst) begin
      exp_done = 1'b0;
    end
    for (int k = 0; k < n; k++) begin
      src = (int'(c.start_address) + k) % main_words;
      if (c.ir_select == loader_pkg::sel_im) begin
        im_model[im_start + k] = main_model[src];
      end else begin
        dm_model[k] = main_model[src];
      end
    end
    if (n > 0 && c.ir_select == loader_pkg::sel_im) begin
      exp_done = 1'b1;
    end
  endtask

  task automatic run_cmd(input loader_pkg::load_cmd_t c);
    send_cmd(c);
    apply_model(c);
    wait_idle();
  endtask

  task automatic check_im(input int lo, input int hi, input string what);
    for (int a = lo; a <= hi; a++) begin
      im_raddr = 10'(a);
      tick();
      check_equal(im_rdata, im_model[a], $sformatf("%s im[%0d]", what, a));
    end
  endtask

  task automatic check_dm(input int lo, input int hi, input string what);
    for (int a = lo; a <= hi; a++) begin
      dm_raddr = 10'(a);
      tick();
      check_equal(dm_rdata, dm_model[a], $sformatf("%s dm[%0d]", what, a));
    end
  endtask

  task automatic check_flags(input string what);
    check_equal(32'(load_im_done), 32'(exp_done), {what, " load_im_done"});
    check_equal(32'(ir_enable), 32'(exp_ir_en), {what, " ir_enable"});
    check_equal(32'(total_ir), 32'(exp_total), {what, " total_ir"});
    check_equal(32'(busy), 32'd0, {what, " busy"});
  endtask

  task automatic preload_main();
    for (int a = 0; a < preload_words; a++) begin
      rng_state     = xorshift32(rng_state);
      main_model[a] = rng_state ^ 32'(a);
      main_we       = 1'b1;
      main_waddr    = 12'(a);
      main_wdata    = main_model[a];
      tick();
    end
    main_we = 1'b0;
  endtask

  task automatic test_im_load();
    // 320 bits is 10 words
    run_cmd(make_cmd(1'b0, 1'b1, loader_pkg::sel_im, 16'd40, 16'd320));
    check_im(im_start, im_start + 9, "im load");
    check_flags("im load");
    check_equal(32'(total_ir), 32'd10, "im load word count");
  endtask

  task automatic test_dm_load();
    // 400 bits rounds down to 12 words
    run_cmd(make_cmd(1'b0, 1'b0, loader_pkg::sel_dm, 16'd70, 16'd400));
    check_dm(0, 11, "dm load");
    check_im(im_start, im_start + 9, "im after dm load");
    check_flags("dm load");
  endtask

  task automatic test_back_pressure();
    loader_pkg::load_cmd_t cmds [6];
    cmds[0] = make_cmd(1'b0, 1'b1, loader_pkg::sel_im, 16'd0, 16'd640);
    cmds[1] = make_cmd(1'b0, 1'b0, loader_pkg::sel_dm, 16'd100, 16'd256);
    cmds[2] = make_cmd(1'b0, 1'b1, loader_pkg::sel_im, 16'd50, 16'd160);
    cmds[3] = make_cmd(1'b0, 1'b0, loader_pkg::sel_dm, 16'd200, 16'd128);
    cmds[4] = make_cmd(1'b0, 1'b1, loader_pkg::sel_im, 16'd60, 16'd96);
    cmds[5] = make_cmd(1'b0, 1'b0, loader_pkg::sel_dm, 16'd150, 16'd64);
    saw_full = 1'b0;
    for (int i = 0; i < 6; i++) begin
      send_cmd(cmds[i]);
      apply_model(cmds[i]);
    end
    wait_idle();
    check_equal(32'(saw_full), 32'd1, "cmd_ready dropped while the queue was full");
    check_im(im_start, im_start + 19, "back-pressure");
    check_dm(0, 11, "back-pressure");
    check_flags("back-pressure");
  endtask

  task automatic test_size_zero();
    // 16 bits is less than one word
    run_cmd(make_cmd(1'b1, 1'b0, loader_pkg::sel_im, 16'd5, 16'd16));
    check_im(im_start, im_start + 19, "done reset");
    check_flags("done reset");
  endtask

  task automatic test_end_of_program();
    run_cmd('0);
    check_equal(32'(eop), 32'd1, "eop after zero command");
    send_cmd(make_cmd(1'b0, 1'b1, loader_pkg::sel_im, 16'd10, 16'd128));
    // ample time for the copy if it were to start
    repeat (20) tick();
    check_equal(32'(busy), 32'd0, "busy after eop");
    check_equal(32'(eop), 32'd1, "eop held");
    check_flags("after eop");
    check_im(im_start, im_start + 19, "after eop");
    reset = 1'b1;
    repeat (2) tick();
    reset     = 1'b0;
    exp_done  = 1'b0;
    exp_ir_en = 1'b0;
    exp_total = '0;
    check_equal(32'(eop), 32'd0, "eop after reset");
    check_flags("after reset");
  endtask

  initial begin
    #(budget_cycles * clk_period);
    abort_run("timeout: the run did not finish in its time budget");
  end

  initial begin
    reset      = 1'b1;
    main_we    = 1'b0;
    main_waddr = '0;
    main_wdata = '0;
    cmd_valid  = 1'b0;
    cmd_data   = '0;
    im_raddr   = '0;
    dm_raddr   = '0;
    rng_state  = 32'd5168;
    saw_full   = 1'b0;
    exp_done   = 1'b0;
    exp_ir_en  = 1'b0;
    exp_total  = '0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    preload_main();
    test_im_load();
    test_dm_load();
    test_back_pressure();
    test_size_zero();
    test_end_of_program();
    $display("NO ERRORS");
    $finish;
  end

endmodule
